// File: core_backend.f
isa_pkg.sv
priv_pkg.sv
retire.sv
reg_bank.sv
data_ram.sv
trap_unit.sv
core_backend.sv
core_backend_checker.sv
tb_core_backend.sv

// File: core_backend.sv
// Back-end top level: retire, register bank, data memory and trap unit
module core_backend #(
    parameter int          TAG_WIDTH   = 3,
    parameter int          RAM_WORDS   = 256,
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [31:0]           instruction_i,
    input  logic [31:0]           pc_i,
    input  logic [31:0]           result0_i,
    input  logic [31:0]           result1_i,
    input  logic [TAG_WIDTH-1:0]  tag_i,
    input  logic [3:0]            mem_write_enable_i,
    input  logic                  write_enable_i,
    input  logic                  jump_i,
    input  isa_pkg::iType_e       instruction_operation_i,
    input  logic                  exception_i,
    input  logic                  irq_i,
    input  logic [4:0]            rs_addr_i,      // Read port for decode
    output logic [31:0]           rs_data_o,
    input  logic [11:0]           csr_addr_i,
    output logic [31:0]           csr_data_o,
    output logic                  redirect_o,
    output logic [31:0]           redirect_pc_o,
    output logic                  killed_o,
    output logic [TAG_WIDTH-1:0]  retire_tag_o
);
    import priv_pkg::*;

    ////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////
    logic           regbank_write_enable;
    logic [4:0]     regbank_addr;
    logic [31:0]    regbank_data;
    logic [31:0]    mem_address;        // Store and load address
    logic [3:0]     mem_write_enable;
    logic [31:0]    mem_write_data;
    logic [31:0]    mem_data;
    logic           interrupt_pending;
    logic [31:0]    trap_target;
    logic [31:0]    trap_pc;
    exceptionCode_e exception_code;
    logic           raise_exception;
    logic           machine_return;
    logic           interrupt_ack;

    retire #(
        .TAG_WIDTH(TAG_WIDTH)
    ) retire_inst (
        .clk                     (clk),
        .reset                   (reset),
        .instruction_i           (instruction_i),
        .pc_i                    (pc_i),
        .result0_i               (result0_i),
        .result1_i               (result1_i),
        .tag_i                   (tag_i),
        .mem_write_enable_i      (mem_write_enable_i),
        .write_enable_i          (write_enable_i),
        .jump_i                  (jump_i),
        .exception_i             (exception_i),
        .interrupt_pending_i     (interrupt_pending),
        .instruction_operation_i (instruction_operation_i),
        .mem_data_i              (mem_data),
        .trap_target_i           (trap_target),
        .regbank_write_enable_o  (regbank_write_enable),
        .regbank_addr_o          (regbank_addr),
        .regbank_data_o          (regbank_data),
        .mem_write_address_o     (mem_address),
        .mem_write_enable_o      (mem_write_enable),
        .mem_data_o              (mem_write_data),
        .redirect_o              (redirect_o),
        .redirect_pc_o           (redirect_pc_o),
        .killed_o                (killed_o),
        .current_retire_tag_o    (retire_tag_o),
        .exception_code_o        (exception_code),
        .raise_exception_o       (raise_exception),
        .machine_return_o        (machine_return),
        .interrupt_ack_o         (interrupt_ack),
        .trap_pc_o               (trap_pc)
    );

    reg_bank reg_bank_inst (
        .clk            (clk),
        .reset          (reset),
        .write_enable_i (regbank_write_enable),
        .write_addr_i   (regbank_addr),
        .write_data_i   (regbank_data),
        .read_addr_i    (rs_addr_i),
        .read_data_o    (rs_data_o)
    );

    data_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) data_ram_inst (
        .clk           (clk),
        .address_i     (mem_address),
        .byte_enable_i (mem_write_enable),
        .write_data_i  (mem_write_data),
        .read_data_o   (mem_data)
    );

    trap_unit #(
        .MTVEC_RESET(MTVEC_RESET)
    ) trap_unit_inst (
        .clk                 (clk),
        .reset               (reset),
        .irq_i               (irq_i),
        .raise_exception_i   (raise_exception),
        .exception_code_i    (exception_code),
        .machine_return_i    (machine_return),
        .interrupt_ack_i     (interrupt_ack),
        .pc_i                (trap_pc),
        .csr_addr_i          (csr_addr_i),
        .csr_data_o          (csr_data_o),
        .interrupt_pending_o (interrupt_pending),
        .trap_target_o       (trap_target)
    );

endmodule

// File: core_backend_checker.sv
// Concurrent assertions on retire kill, write enables, tag update and reset, with a failure count
module core_backend_checker #(
    parameter int TAG_WIDTH = 3
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 killed_o,
    input  logic                 redirect_o,
    input  logic                 interrupt_ack_o,
    input  logic                 regbank_write_enable_o,
    input  logic [3:0]           mem_write_enable_o,
    input  logic [TAG_WIDTH-1:0] current_retire_tag_o
);

    int failures = 0;   // Failed assertions so far

    // A killed slot may only redirect through an interrupt
    redirect_not_killed: assert property (@(posedge clk) disable iff (reset)
        !(redirect_o && killed_o && !interrupt_ack_o))
        else begin
            failures++;
            $error("redirect on a killed instruction");
        end

    no_write_when_killed: assert property (@(posedge clk) disable iff (reset)
        killed_o |-> (!regbank_write_enable_o && mem_write_enable_o == 4'b0000))
        else begin
            failures++;
            $error("write enable active on a killed instruction");
        end

    // Tag moves only one edge after a redirect or interrupt acknowledge
    tag_moves_on_redirect: assert property (@(posedge clk) disable iff (reset)
        !$stable(current_retire_tag_o) |-> ($past(redirect_o) || $past(interrupt_ack_o)
                                            || $past(reset)))
        else begin
            failures++;
            $error("retire tag changed without a redirect");
        end

    quiet_in_reset: assert property (@(posedge clk)
        reset |-> (!regbank_write_enable_o && mem_write_enable_o == 4'b0000 && !redirect_o))
        else begin
            failures++;
            $error("retire output active during reset");
        end

endmodule

bind retire core_backend_checker #(.TAG_WIDTH(TAG_WIDTH)) checker_inst (
    .clk                    (clk),
    .reset                  (reset),
    .killed_o               (killed_o),
    .redirect_o             (redirect_o),
    .interrupt_ack_o        (interrupt_ack_o),
    .regbank_write_enable_o (regbank_write_enable_o),
    .mem_write_enable_o     (mem_write_enable_o),
    .current_retire_tag_o   (current_retire_tag_o)
);

// File: data_ram.sv
// Word-addressed data memory, asynchronous read, byte-enable synchronous write
module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic                          clk,
    input  logic [isa_pkg::XLEN-1:0]      address_i,      // Byte address
    input  logic [isa_pkg::BYTE_LANES-1:0] byte_enable_i,
    input  logic [isa_pkg::XLEN-1:0]      write_data_i,
    output logic [isa_pkg::XLEN-1:0]      read_data_o
);
    import isa_pkg::*;

    localparam int INDEX_W = $clog2(RAM_WORDS);

    logic [XLEN-1:0]    mem [RAM_WORDS];
    logic [INDEX_W-1:0] word_index;

    assign word_index = address_i[INDEX_W+1:2];     // Drop the byte offset

    ////////////////////////////////////////
    // One write per set byte lane
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < BYTE_LANES; lane++) begin
            if (byte_enable_i[lane]) begin
                mem[word_index][8*lane +: 8] <= write_data_i[8*lane +: 8];
            end
        end
    end

    assign read_data_o = mem[word_index];   // Same cycle read

endmodule

// File: isa_pkg.sv
// Opcode enum, execution-unit enum and data-width constants
package isa_pkg;

    ////////////////////////////////////////
    // Data widths
    ////////////////////////////////////////
    localparam int XLEN       = 32;         // Data word width
    localparam int BYTE_LANES = XLEN / 8;   // Byte enables per word
    localparam int REG_ADDR_W = 5;          // 32 architectural registers

    ////////////////////////////////////////
    // Execution units, upper three opcode bits
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        ADDER_UNIT  = 3'b000,
        MEMORY_UNIT = 3'b001,
        BRANCH_UNIT = 3'b010,
        BYPASS_UNIT = 3'b011
    } executionUnit_e;

    ////////////////////////////////////////
    // Opcodes as {unit, operation}
    ////////////////////////////////////////
    typedef enum logic [5:0] {
        ADD    = 6'b000_000,
        LB     = 6'b001_000,    // Loads share the memory unit
        LBU    = 6'b001_001,
        LH     = 6'b001_010,
        LHU    = 6'b001_011,
        LW     = 6'b001_100,
        SB     = 6'b001_101,    // Stores too
        SH     = 6'b001_110,
        SW     = 6'b001_111,
        BEQ    = 6'b010_000,
        JAL    = 6'b010_001,
        ECALL  = 6'b011_000,    // System ops go through bypass
        EBREAK = 6'b011_001,
        MRET   = 6'b011_010,
        NOP    = 6'b011_111
    } iType_e;

endpackage

// File: priv_pkg.sv
// Exception codes, machine CSR addresses and the interrupt cause value
package priv_pkg;

    ////////////////////////////////////////
    // Synchronous exception causes
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        NE                  = 4'd0,     // No exception
        ILLEGAL_INSTRUCTION = 4'd2,
        BREAKPOINT          = 4'd3,
        ECALL_FROM_MMODE    = 4'd11
    } exceptionCode_e;

    // Machine external interrupt, interrupt bit on top
    localparam logic [31:0] MCAUSE_IRQ = 32'h8000_000B;

    ////////////////////////////////////////
    // CSR addresses
    ////////////////////////////////////////
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // Bit positions inside mstatus
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

endpackage

// File: reg_bank.sv
// Register bank, 32 by 32 bits, one write port, one read port, x0 tied to zero
module reg_bank (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          write_enable_i,
    input  logic [isa_pkg::REG_ADDR_W-1:0] write_addr_i,
    input  logic [isa_pkg::XLEN-1:0]      write_data_i,
    input  logic [isa_pkg::REG_ADDR_W-1:0] read_addr_i,
    output logic [isa_pkg::XLEN-1:0]      read_data_o
);
    import isa_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0] regs [NUM_REGS];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable_i && write_addr_i != '0) begin
            regs[write_addr_i] <= write_data_i;     // Writes to x0 dropped
        end
    end

    // Asynchronous read, x0 forced to zero
    assign read_data_o = (read_addr_i == '0) ? '0 : regs[read_addr_i];

endmodule

// File: retire.sv
// Retire stage: tag check, write-back, load alignment, store gating, trap decision
module retire #(
    parameter int TAG_WIDTH = 3
) (
    input  logic                          clk,
    input  logic                          reset,

    input  logic [31:0]                   instruction_i,
    input  logic [31:0]                   pc_i,
    input  logic [31:0]                   result0_i,      // ALU result or store data
    input  logic [31:0]                   result1_i,      // Address or jump target
    input  logic [TAG_WIDTH-1:0]          tag_i,
    input  logic [3:0]                    mem_write_enable_i,
    input  logic                          write_enable_i,
    input  logic                          jump_i,
    input  logic                          exception_i,    // Illegal instruction from decode
    input  logic                          interrupt_pending_i,
    input  isa_pkg::iType_e               instruction_operation_i,
    input  logic [31:0]                   mem_data_i,     // Word read at result1
    input  logic [31:0]                   trap_target_i,

    output logic                          regbank_write_enable_o,
    output logic [4:0]                    regbank_addr_o,
    output logic [31:0]                   regbank_data_o,
    output logic [31:0]                   mem_write_address_o,
    output logic [3:0]                    mem_write_enable_o,
    output logic [31:0]                   mem_data_o,
    output logic                          redirect_o,
    output logic [31:0]                   redirect_pc_o,
    output logic                          killed_o,
    output logic [TAG_WIDTH-1:0]          current_retire_tag_o,
    output priv_pkg::exceptionCode_e      exception_code_o,
    output logic                          raise_exception_o,
    output logic                          machine_return_o,
    output logic                          interrupt_ack_o,
    output logic [31:0]                   trap_pc_o       // Saved into mepc
);
    import isa_pkg::*;
    import priv_pkg::*;

    logic [TAG_WIDTH-1:0] curr_tag;
    logic                 killed;
    logic                 jump_live;          // Jump of a live instruction
    logic                 trap_taken;         // Exception, mret or interrupt
    logic [7:0]           load_byte;
    logic [15:0]          load_half;
    logic [XLEN-1:0]      load_data;
    executionUnit_e       execution_unit;

    assign execution_unit = executionUnit_e'(instruction_operation_i[5:3]);

    ////////////////////////////////////////
    // Tag check and tag update
    ////////////////////////////////////////
    assign killed               = (tag_i != curr_tag);  // Wrong-path shadow
    assign killed_o             = killed;
    assign current_retire_tag_o = curr_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (redirect_o) begin
            curr_tag <= curr_tag + 1'b1;    // Every redirect opens a new path
        end
    end

    ////////////////////////////////////////
    // Load alignment and write-back
    ////////////////////////////////////////
    always_comb begin
        case (result1_i[1:0])
            2'b01:   load_byte = mem_data_i[15:8];
            2'b10:   load_byte = mem_data_i[23:16];
            2'b11:   load_byte = mem_data_i[31:24];
            default: load_byte = mem_data_i[7:0];
        endcase
        load_half = result1_i[1] ? mem_data_i[31:16] : mem_data_i[15:0];

        case (instruction_operation_i)
            LB:      load_data = {{(XLEN-8){load_byte[7]}}, load_byte};
            LBU:     load_data = {{(XLEN-8){1'b0}}, load_byte};
            LH:      load_data = {{(XLEN-16){load_half[15]}}, load_half};
            LHU:     load_data = {{(XLEN-16){1'b0}}, load_half};
            default: load_data = mem_data_i;    // LW
        endcase
    end

    assign regbank_data_o         = (execution_unit == MEMORY_UNIT) ? load_data : result0_i;
    assign regbank_addr_o         = instruction_i[11:7];    // rd field
    assign regbank_write_enable_o = write_enable_i && !killed;

    ////////////////////////////////////////
    // Store gating
    ////////////////////////////////////////
    assign mem_write_address_o = result1_i;     // Also the load address
    assign mem_data_o          = result0_i;     // Already lane aligned by execute
    assign mem_write_enable_o  = killed ? 4'b0000 : mem_write_enable_i;

    ////////////////////////////////////////
    // Trap decision
    ////////////////////////////////////////
    always_comb begin
        raise_exception_o = 1'b0;
        exception_code_o  = NE;
        machine_return_o  = 1'b0;
        interrupt_ack_o   = 1'b0;
        if (!killed && exception_i) begin
            raise_exception_o = 1'b1;
            exception_code_o  = ILLEGAL_INSTRUCTION;
        end else if (!killed && instruction_operation_i == ECALL) begin
            raise_exception_o = 1'b1;
            exception_code_o  = ECALL_FROM_MMODE;
        end else if (!killed && instruction_operation_i == EBREAK) begin
            raise_exception_o = 1'b1;
            exception_code_o  = BREAKPOINT;
        end else if (!killed && instruction_operation_i == MRET) begin
            machine_return_o = 1'b1;
        end else if (interrupt_pending_i && !jump_i) begin
            interrupt_ack_o = 1'b1;     // Taken even in a killed slot
        end
    end

    assign trap_pc_o = pc_i;

    ////////////////////////////////////////
    // Redirect merge, trap wins over jump
    ////////////////////////////////////////
    assign jump_live  = jump_i && !killed;
    assign trap_taken = raise_exception_o || machine_return_o || interrupt_ack_o;
    assign redirect_o = jump_live || trap_taken;

    always_comb begin
        if (trap_taken) begin
            redirect_pc_o = trap_target_i;      // mtvec or mepc
        end else if (jump_live) begin
            redirect_pc_o = result1_i;
        end else begin
            redirect_pc_o = '0;
        end
    end

endmodule

// File: tb_core_backend.sv
// Testbench for core_backend: stimulus, reference model, compare process and report
module tb_core_backend;
    import isa_pkg::*;
    import priv_pkg::*;

    localparam logic [31:0] MTVEC = 32'h0000_0100;

    typedef struct packed {
        logic        killed;
        logic        redirect;
        logic [31:0] redirect_pc;
        logic [2:0]  tag;           // Retire tag in the same cycle
        logic [31:0] rs_val;
        logic [31:0] csr_val;
    } expect_t;

    logic clk, reset, write_enable_i, jump_i, exception_i, irq_i;
    logic [31:0] instruction_i, pc_i, result0_i, result1_i, rs_data_o, csr_data_o, redirect_pc_o;
    logic [2:0] tag_i, retire_tag_o;
    logic [3:0] mem_write_enable_i;
    logic [4:0] rs_addr_i;
    logic [11:0] csr_addr_i;
    logic redirect_o, killed_o;
    iType_e instruction_operation_i;

    expect_t expq[$];
    int errors = 0;
    int checks = 0;
    integer seed = 75;
    logic [31:0] pc_cnt = 32'h1000;

    // Model state
    logic [31:0] m_regs [32];
    logic [31:0] m_mem [int];
    logic [31:0] m_mepc, m_mcause;
    logic m_mie, m_mpie;
    logic [2:0] m_tag;

    core_backend #(.TAG_WIDTH(3), .RAM_WORDS(256), .MTVEC_RESET(MTVEC)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] csr_model(logic [11:0] addr);
        case (addr)
            CSR_MEPC:    return m_mepc;
            CSR_MCAUSE:  return m_mcause;
            CSR_MTVEC:   return MTVEC;
            CSR_MSTATUS: return (32'(m_mpie) << 7) | (32'(m_mie) << 3);
            default:     return 32'h0;
        endcase
    endfunction

    ////////////////////////////////////////
    // Reference model, one call per instruction
    ////////////////////////////////////////
    function automatic expect_t predict(iType_e op, logic [4:0] rd, logic [31:0] pc,
            logic [31:0] r0, logic [31:0] r1, logic [2:0] tag, logic we, logic [3:0] mwe,
            logic jmp, logic exc, logic irq, logic [4:0] rs, logic [11:0] csr);
        expect_t e;
        logic live, trap, mret, ack;
        logic [31:0] word, wb, code;
        logic [7:0] b;
        logic [15:0] h;
        int idx;
        e = '0;
        live = (tag == m_tag);
        e.tag = m_tag;
        idx = r1[9:2];
        word = m_mem.exists(idx) ? m_mem[idx] : 32'h0;
        b = word >> (8 * r1[1:0]);
        h = r1[1] ? word[31:16] : word[15:0];
        trap = 1'b1;
        mret = 1'b0;
        ack = 1'b0;
        code = 0;
        if (live && exc) code = 2;
        else if (live && op == ECALL) code = 11;
        else if (live && op == EBREAK) code = 3;
        else if (live && op == MRET) mret = 1'b1;
        else if (irq && m_mie && !jmp) ack = 1'b1;
        else trap = 1'b0;
        e.killed = !live;
        e.redirect = trap || (jmp && live);
        e.redirect_pc = mret ? m_mepc : (trap ? MTVEC : (e.redirect ? r1 : 32'h0));
        e.rs_val = (rs == 0) ? 32'h0 : m_regs[rs];
        e.csr_val = csr_model(csr);
        case (op)   // Load extension
            LB:      wb = {{24{b[7]}}, b};
            LBU:     wb = {24'h0, b};
            LH:      wb = {{16{h[15]}}, h};
            LHU:     wb = {16'h0, h};
            LW:      wb = word;
            default: wb = r0;
        endcase
        if (live && we && rd != 0) m_regs[rd] = wb;
        for (int l = 0; l < 4; l++) begin
            if (live && mwe[l]) begin
                word[8*l +: 8] = r0[8*l +: 8];
            end
        end
        if (live && mwe != 0) m_mem[idx] = word;
        if (code != 0 || ack) begin
            m_mepc = pc;
            m_mcause = ack ? MCAUSE_IRQ : code;
            m_mpie = m_mie;
            m_mie = 1'b0;
        end else if (mret) begin
            m_mie = m_mpie;
        end
        if (e.redirect) m_tag = m_tag + 1;
        return e;
    endfunction

    task automatic issue(iType_e op, logic [4:0] rd, logic [31:0] r0, logic [31:0] r1,
            logic [2:0] tag, logic we, logic [3:0] mwe, logic jmp, logic exc, logic irq,
            logic [4:0] rs, logic [11:0] csr);
        @(posedge clk);
        instruction_i <= {20'h0, rd, 7'h0};
        pc_i <= pc_cnt;
        result0_i <= r0;
        result1_i <= r1;
        tag_i <= tag;
        write_enable_i <= we;
        mem_write_enable_i <= mwe;
        jump_i <= jmp;
        exception_i <= exc;
        irq_i <= irq;
        instruction_operation_i <= op;
        rs_addr_i <= rs;
        csr_addr_i <= csr;
        expq.push_back(predict(op, rd, pc_cnt, r0, r1, tag, we, mwe, jmp, exc, irq, rs, csr));
        pc_cnt += 4;
    endtask

    task automatic read_back(logic [4:0] rs, logic [11:0] csr);
        issue(NOP, 0, 0, 0, m_tag, 0, 0, 0, 0, 0, rs, csr);
    endtask

    task automatic compare(string name, logic [31:0] actual, logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: got %h expected %h", name, actual, expected);
        end
    endtask

    // Compare on the falling edge, inputs and state settled
    always @(negedge clk) begin
        expect_t e;
        if (!reset && expq.size() > 0) begin
            e = expq.pop_front();
            compare("killed_o", killed_o, e.killed);
            compare("redirect_o", redirect_o, e.redirect);
            compare("redirect_pc_o", redirect_pc_o, e.redirect_pc);
            compare("retire_tag_o", retire_tag_o, e.tag);
            compare("rs_data_o", rs_data_o, e.rs_val);
            compare("csr_data_o", csr_data_o, e.csr_val);
        end
    end

    task automatic end_test(string name, int start_errors);
        int waited;
        waited = 0;
        @(posedge clk);
        instruction_operation_i <= NOP;     // Idle slot while draining
        write_enable_i <= 1'b0;
        mem_write_enable_i <= 4'h0;
        jump_i <= 1'b0;
        exception_i <= 1'b0;
        irq_i <= 1'b0;
        tag_i <= m_tag;
        while (expq.size() > 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (expq.size() > 0) begin
            $display("timeout: compare queue did not drain in test %s", name);
            $display("Testbench failed");
            $finish;
        end else begin
            $display("test %s finished with %0d errors", name, errors - start_errors);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        int s;
        logic [4:0] rd;
        logic [31:0] v;
        reset = 1'b1;
        {instruction_i, pc_i, result0_i, result1_i, tag_i} = '0;
        {write_enable_i, jump_i, exception_i, irq_i, mem_write_enable_i} = '0;
        {rs_addr_i, csr_addr_i} = '0;
        instruction_operation_i = NOP;
        for (int i = 0; i < 32; i++) m_regs[i] = 32'h0;
        {m_mepc, m_mcause, m_mpie, m_tag} = '0;
        m_mie = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        s = errors;     // ALU write-back, x0 included
        for (int i = 0; i < 10; i++) begin
            rd = (i == 0) ? 5'd0 : $random(seed);
            v = $random(seed);
            issue(ADD, rd, v, 0, m_tag, 1, 0, 0, 0, 0, 0, 0);
            read_back(rd, 0);
        end
        end_test("alu_writeback", s);

        s = errors;     // Stores then loads at each offset
        issue(SW, 0, $random(seed), 32'h40, m_tag, 0, 4'hF, 0, 0, 0, 0, 0);
        issue(SW, 0, $random(seed), 32'h44, m_tag, 0, 4'hF, 0, 0, 0, 0, 0);
        issue(SH, 0, 32'h8765_0000, 32'h46, m_tag, 0, 4'hC, 0, 0, 0, 0, 0);
        issue(SB, 0, 32'h0000_F100, 32'h41, m_tag, 0, 4'h2, 0, 0, 0, 0, 0);
        for (int a = 32'h40; a < 32'h48; a++) begin
            issue(LB, 5, 0, a, m_tag, 1, 0, 0, 0, 0, 0, 0);
            read_back(5, 0);
            issue(LBU, 6, 0, a, m_tag, 1, 0, 0, 0, 0, 0, 0);
            read_back(6, 0);
            issue(a[0] ? LW : LH, 7, 0, a & ~32'h1, m_tag, 1, 0, 0, 0, 0, 0, 0);
            read_back(7, 0);
            issue(LHU, 8, 0, a & ~32'h1, m_tag, 1, 0, 0, 0, 0, 0, 0);
            read_back(8, 0);
        end
        end_test("store_load", s);

        s = errors;     // Live jump, then wrong-path shadow
        issue(JAL, 0, 0, 32'h200, m_tag, 0, 0, 1, 0, 0, 0, 0);
        issue(ADD, 9, 32'hDEAD_BEEF, 0, m_tag - 1, 1, 0, 0, 0, 0, 0, 0);
        issue(SW, 0, 32'h1234_5678, 32'h40, m_tag - 1, 0, 4'hF, 0, 0, 0, 0, 0);
        issue(LW, 9, 0, 32'h40, m_tag, 1, 0, 0, 0, 0, 9, 0);
        read_back(9, 0);
        end_test("jump_kill", s);

        s = errors;     // Interrupt, ignored repeat, mret
        issue(NOP, 0, 0, 0, m_tag, 0, 0, 0, 0, 1, 0, CSR_MSTATUS);
        issue(NOP, 0, 0, 0, m_tag, 0, 0, 0, 0, 1, 0, CSR_MCAUSE);
        read_back(0, CSR_MSTATUS);
        issue(MRET, 0, 0, 0, m_tag, 0, 0, 0, 0, 0, 0, CSR_MEPC);
        read_back(0, CSR_MSTATUS);
        end_test("interrupt_mret", s);

        s = errors;     // Illegal, ecall, ebreak
        issue(ADD, 0, 0, 0, m_tag, 0, 0, 0, 1, 0, 0, 0);
        read_back(0, CSR_MEPC);
        read_back(0, CSR_MCAUSE);
        issue(ECALL, 0, 0, 0, m_tag, 0, 0, 0, 0, 0, 0, 0);
        read_back(0, CSR_MCAUSE);
        issue(EBREAK, 0, 0, 0, m_tag, 0, 0, 0, 0, 0, 0, CSR_MTVEC);
        read_back(0, CSR_MEPC);
        read_back(0, CSR_MCAUSE);
        end_test("exceptions", s);

        errors += uut.retire_inst.checker_inst.failures;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: trap_unit.sv
// Machine trap CSRs, interrupt enable pair and redirect target selection
module trap_unit #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          irq_i,          // Machine external interrupt
    input  logic                          raise_exception_i,
    input  priv_pkg::exceptionCode_e      exception_code_i,
    input  logic                          machine_return_i,
    input  logic                          interrupt_ack_i,
    input  logic [31:0]                   pc_i,
    input  logic [11:0]                   csr_addr_i,
    output logic [31:0]                   csr_data_o,
    output logic                          interrupt_pending_o,
    output logic [31:0]                   trap_target_o
);
    import priv_pkg::*;

    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mstatus;
    logic        mie;       // Global machine interrupt enable
    logic        mpie;      // Enable saved on trap entry

    ////////////////////////////////////////
    // Trap entry and return
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            mepc   <= '0;
            mcause <= '0;
            mie    <= 1'b1;
            mpie   <= 1'b0;
        end else if (raise_exception_i) begin
            mepc   <= pc_i;
            mcause <= {28'b0, exception_code_i};
            mpie   <= mie;
            mie    <= 1'b0;                 // Block nesting
        end else if (interrupt_ack_i) begin
            mepc   <= pc_i;
            mcause <= MCAUSE_IRQ;
            mpie   <= mie;
            mie    <= 1'b0;
        end else if (machine_return_i) begin
            mie    <= mpie;                 // Restore saved enable
        end
    end

    assign interrupt_pending_o = irq_i && mie;
    assign trap_target_o       = machine_return_i ? mepc : MTVEC_RESET;   // mepc or trap vector

    ////////////////////////////////////////
    // CSR read port
    ////////////////////////////////////////
    always_comb begin
        mstatus                   = '0;
        mstatus[MSTATUS_MIE_BIT]  = mie;
        mstatus[MSTATUS_MPIE_BIT] = mpie;
        case (csr_addr_i)
            CSR_MEPC:    csr_data_o = mepc;
            CSR_MCAUSE:  csr_data_o = mcause;
            CSR_MTVEC:   csr_data_o = MTVEC_RESET;  // No write path, vector fixed
            CSR_MSTATUS: csr_data_o = mstatus;
            default:     csr_data_o = '0;       // Unmapped reads as zero
        endcase
    end

endmodule
